// ==== logic/lsu_cfg.svh ====
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Datapath width of the core
`define LSU_XLEN 32

`define LSU_DEPTH 4       // Entries between issue and the memory port
`define LSU_MEM_WORDS 256 // Depth of the data RAM in words

// RV32 funct3 codes for loads and stores
`define LSU_SIZE_B  3'd0
`define LSU_SIZE_H  3'd1
`define LSU_SIZE_W  3'd2
`define LSU_SIZE_BU 3'd4
`define LSU_SIZE_HU 3'd5

`endif

// ==== logic/lsu_pkg.sv ====
`include "lsu_cfg.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]   word_t;
    typedef logic [`LSU_XLEN-1:0]   addr_t;
    typedef logic [2:0]             funct3_t;
    typedef logic [`LSU_XLEN/8-1:0] strb_t;

    // Operation as it arrives from the pipeline
    typedef struct packed {
        logic    is_store;
        funct3_t size;
        addr_t   base;
        addr_t   offset;
        word_t   wdata;
    } lsu_req_t;

    typedef struct packed {
        logic    is_store;
        logic    fault;    // Misaligned, never reaches the RAM
        funct3_t size;
        addr_t   addr;     // Effective byte address
        word_t   wdata;
    } lsu_entry_t;

    typedef struct packed {
        logic  fault;
        addr_t addr;
        word_t data;
    } lsu_resp_t;

    typedef enum logic [1:0] {IDLE, WAIT, WAIT2} port_state_e;

endpackage

// ==== logic/lsu_issue.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_issue (
    input  logic                clk_in,
    input  logic                rst_in,
    input  logic                req_valid,
    input  lsu_pkg::lsu_req_t   req,
    output logic                req_ready,
    input  logic                full,
    output logic                push,
    output lsu_pkg::lsu_entry_t entry
);
    lsu_pkg::addr_t eff_addr;
    logic           misaligned;
    logic           out_valid;
    logic           accept;

    assign eff_addr = req.base + req.offset;
    assign accept = req_valid && req_ready;

    // Halves need an even address and words need a multiple of four
    always_comb begin
        case (req.size)
            `LSU_SIZE_H, `LSU_SIZE_HU: misaligned = eff_addr[0];
            `LSU_SIZE_W:               misaligned = |eff_addr[1:0];
            default:                   misaligned = 1'b0;
        endcase
    end

    assign push = out_valid && !full;
    assign req_ready = !out_valid || push; // Slot frees as its entry moves on

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (push) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            entry.is_store <= req.is_store;
            entry.fault <= misaligned;
            entry.size <= req.size;
            entry.addr <= eff_addr;
            entry.wdata <= req.wdata;
        end
    end
endmodule

// ==== logic/lsu_req_fifo.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_req_fifo (
    input  logic                clk_in,
    input  logic                rst_in,
    input  logic                push,
    input  lsu_pkg::lsu_entry_t wr_entry,
    output logic                full,
    input  logic                pop,
    output lsu_pkg::lsu_entry_t head,
    output logic                empty
);
    localparam int PTR_W = (`LSU_DEPTH > 1) ? $clog2(`LSU_DEPTH) : 1;
    localparam int CNT_W = $clog2(`LSU_DEPTH + 1);

    lsu_pkg::lsu_entry_t mem [`LSU_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                do_push;
    logic                do_pop;

    // Wraps by hand so the depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`LSU_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full = (count == CNT_W'(`LSU_DEPTH));
    assign empty = (count == '0);
    assign do_push = push && !full;
    assign do_pop = pop && !empty;
    assign head = mem[rd_ptr];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk_in) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_entry;
        end
    end
endmodule

// ==== logic/dcache_port.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module dcache_port (
    input  logic                clk_in,
    input  logic                rst_in,
    input  lsu_pkg::lsu_entry_t head,
    input  logic                empty,
    output logic                pop,
    output lsu_pkg::addr_t      mem_addr,
    output lsu_pkg::word_t      mem_wdata,
    output lsu_pkg::strb_t      mem_strb,
    input  lsu_pkg::word_t      mem_rdata,
    output logic                resp_valid,
    output lsu_pkg::lsu_resp_t  resp
);
    lsu_pkg::port_state_e state;
    lsu_pkg::addr_t       word_idx;
    lsu_pkg::addr_t       tag_addr;
    lsu_pkg::word_t       tag_data;
    lsu_pkg::word_t       load_word;
    logic                 tag_valid;
    logic                 tag_hit;
    logic                 is_load;
    logic                 do_store;

    // Picks the addressed byte or half out of a word and extends it
    function automatic lsu_pkg::word_t load_extend(input lsu_pkg::word_t w,
                                                   input lsu_pkg::funct3_t sz,
                                                   input logic [1:0] ofs);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[{ofs, 3'b000} +: 8];
        h = ofs[1] ? w[31:16] : w[15:0];
        case (sz)
            `LSU_SIZE_B:  return {{24{b[7]}}, b};
            `LSU_SIZE_BU: return {24'b0, b};
            `LSU_SIZE_H:  return {{16{h[15]}}, h};
            `LSU_SIZE_HU: return {16'b0, h};
            `LSU_SIZE_W:  return w;
            default:      return '0;
        endcase
    endfunction

    assign word_idx = {2'b00, head.addr[`LSU_XLEN-1:2]};
    assign mem_addr = word_idx; // Held steady while a miss waits
    assign is_load = !empty && !head.is_store && !head.fault;
    assign do_store = (state == lsu_pkg::IDLE) && !empty && head.is_store && !head.fault;
    assign tag_hit = tag_valid && (tag_addr == word_idx);
    assign load_word = (state == lsu_pkg::WAIT2) ? mem_rdata : tag_data;

    // Stores, faults and hits leave at once, misses leave from WAIT2
    always_comb begin
        if (state == lsu_pkg::WAIT2) begin
            pop = 1'b1;
        end else if (state == lsu_pkg::IDLE && !empty) begin
            pop = head.is_store || head.fault || tag_hit;
        end else begin
            pop = 1'b0;
        end
    end

    always_comb begin
        mem_wdata = head.wdata;
        mem_strb = '0;
        if (do_store) begin
            case (head.size)
                `LSU_SIZE_B: begin
                    mem_wdata = {4{head.wdata[7:0]}};
                    mem_strb = 4'b0001 << head.addr[1:0];
                end
                `LSU_SIZE_H: begin
                    mem_wdata = {2{head.wdata[15:0]}};
                    mem_strb = head.addr[1] ? 4'b1100 : 4'b0011;
                end
                `LSU_SIZE_W: mem_strb = 4'b1111;
                default:     mem_strb = '0; // Unknown size codes write nothing
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= lsu_pkg::IDLE;
        end else begin
            case (state)
                lsu_pkg::IDLE: if (is_load && !tag_hit) state <= lsu_pkg::WAIT;
                lsu_pkg::WAIT: state <= lsu_pkg::WAIT2;
                default:       state <= lsu_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            tag_valid <= 1'b0;
        end else if (pop && head.is_store) begin
            tag_valid <= 1'b0; // Any store may change the tagged word
        end else if (state == lsu_pkg::WAIT2) begin
            tag_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == lsu_pkg::WAIT2) begin
            tag_addr <= word_idx;
            tag_data <= mem_rdata;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= pop && (head.fault || !head.is_store);
        end
    end

    always_ff @(posedge clk_in) begin
        if (pop) begin
            resp.fault <= head.fault;
            resp.addr <= head.addr;
            resp.data <= head.fault ? '0 : load_extend(load_word, head.size, head.addr[1:0]);
        end
    end
endmodule

// ==== logic/dmem_bram.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module dmem_bram (
    input  logic           clk_in,
    input  lsu_pkg::addr_t addr,
    input  lsu_pkg::word_t wdata,
    input  lsu_pkg::strb_t strb,
    output lsu_pkg::word_t rdata
);
    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);
    localparam int LANES = `LSU_XLEN / 8;

    lsu_pkg::word_t   mem [`LSU_MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] idx_q;

    assign idx = addr[IDX_W-1:0]; // Word index wraps at the RAM size

    // Byte lanes write independently
    always_ff @(posedge clk_in) begin
        for (int i = 0; i < LANES; i++) begin
            if (strb[i]) begin
                mem[idx][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // Address stage then output stage, two edges in all
    always_ff @(posedge clk_in) begin
        idx_q <= idx;
    end

    always_ff @(posedge clk_in) begin
        rdata <= mem[idx_q];
    end
endmodule

// ==== logic/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               req_valid,
    input  lsu_pkg::lsu_req_t  req,
    output logic               req_ready,
    output logic               resp_valid,
    output lsu_pkg::lsu_resp_t resp
);
    lsu_pkg::lsu_entry_t issue_entry;
    lsu_pkg::lsu_entry_t fifo_head;
    logic                fifo_push;
    logic                fifo_full;
    logic                fifo_pop;
    logic                fifo_empty;
    lsu_pkg::addr_t      mem_addr;
    lsu_pkg::word_t      mem_wdata;
    lsu_pkg::strb_t      mem_strb;
    lsu_pkg::word_t      mem_rdata;

    lsu_issue i_issue (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .full      (fifo_full),
        .push      (fifo_push),
        .entry     (issue_entry)
    );

    lsu_req_fifo i_fifo (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .push     (fifo_push),
        .wr_entry (issue_entry),
        .full     (fifo_full),
        .pop      (fifo_pop),
        .head     (fifo_head),
        .empty    (fifo_empty)
    );

    dcache_port i_port (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .head       (fifo_head),
        .empty      (fifo_empty),
        .pop        (fifo_pop),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_strb   (mem_strb),
        .mem_rdata  (mem_rdata),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    dmem_bram i_bram (
        .clk_in (clk_in),
        .addr   (mem_addr),
        .wdata  (mem_wdata),
        .strb   (mem_strb),
        .rdata  (mem_rdata)
    );
endmodule

// ==== sim/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_in
);
    initial begin
        clk_in = 1'b0;
    end

    always #2 clk_in = ~clk_in; // 4 ns period
endmodule

// ==== sim/tb_lsu.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tb_lsu;
    logic               clk_in;
    logic               rst_in;
    logic               req_valid;
    lsu_pkg::lsu_req_t  req;
    logic               req_ready;
    logic               resp_valid;
    lsu_pkg::lsu_resp_t resp;

    logic [7:0]         model [`LSU_MEM_WORDS*4]; // Byte image of the data RAM
    lsu_pkg::lsu_resp_t exp_q [$];
    lsu_pkg::lsu_resp_t exp_head;
    lsu_pkg::funct3_t   sizes [5] = '{`LSU_SIZE_B, `LSU_SIZE_H, `LSU_SIZE_W,
                                      `LSU_SIZE_BU, `LSU_SIZE_HU};
    int                 issued = 0;
    int                 cycles = 0;
    int                 seed = 91305;

    tb_clkgen i_clkgen (.clk_in(clk_in));

    lsu_top i_dut (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // Start pattern for word i where every byte depends on the index
    function automatic lsu_pkg::word_t fill_word(input int i);
        logic [7:0] b;
        b = i[7:0];
        return {b ^ 8'hC3, b * 8'd7, ~b, b + 8'h80};
    endfunction

    function automatic lsu_pkg::lsu_req_t make_req(input logic st, input lsu_pkg::funct3_t sz,
                                                   input lsu_pkg::addr_t base,
                                                   input lsu_pkg::addr_t off,
                                                   input lsu_pkg::word_t wd);
        lsu_pkg::lsu_req_t r;
        r.is_store = st;
        r.size = sz;
        r.base = base;
        r.offset = off;
        r.wdata = wd;
        return r;
    endfunction

    // Applies one request to the byte model and predicts its response
    function automatic void ref_access(input lsu_pkg::lsu_req_t r, output logic has_resp,
                                       output lsu_pkg::lsu_resp_t exp);
        lsu_pkg::addr_t ea;
        logic           fault;
        logic [1:0]     ln;
        logic [7:0]     by;
        logic [15:0]    hw;
        int             b;
        ea = r.base + r.offset;
        ln = ea[1:0];
        fault = ((r.size == `LSU_SIZE_H || r.size == `LSU_SIZE_HU) && ea[0]) ||
                (r.size == `LSU_SIZE_W && ln != 2'b00);
        b = int'((ea >> 2) % `LSU_MEM_WORDS) * 4;
        has_resp = fault || !r.is_store;
        exp.fault = fault;
        exp.addr = ea;
        exp.data = '0;
        if (fault) return; // Misaligned accesses leave memory alone
        if (r.is_store) begin
            case (r.size)
                `LSU_SIZE_B: model[b+ln] = r.wdata[7:0];
                `LSU_SIZE_H: begin
                    model[b+ln] = r.wdata[7:0];
                    model[b+ln+1] = r.wdata[15:8];
                end
                `LSU_SIZE_W: for (int k = 0; k < 4; k++) model[b+k] = r.wdata[8*k +: 8];
                default: ;
            endcase
        end else begin
            by = model[b+ln];
            if (r.size == `LSU_SIZE_H || r.size == `LSU_SIZE_HU) hw = {model[b+ln+1], by};
            case (r.size)
                `LSU_SIZE_B:  exp.data = {{24{by[7]}}, by};
                `LSU_SIZE_BU: exp.data = {24'h0, by};
                `LSU_SIZE_H:  exp.data = {{16{hw[15]}}, hw};
                `LSU_SIZE_HU: exp.data = {16'h0, hw};
                `LSU_SIZE_W:  exp.data = {model[b+3], model[b+2], model[b+1], model[b]};
                default:      exp.data = '0;
            endcase
        end
    endfunction

    // Entered and left at 1 ns after a rising edge
    task automatic send_req(input lsu_pkg::lsu_req_t r);
        logic               has_resp;
        lsu_pkg::lsu_resp_t e;
        req = r;
        req_valid = 1'b1;
        @(negedge clk_in);
        while (req_ready !== 1'b1) begin
            @(posedge clk_in);
            #1;
            @(negedge clk_in);
        end
        ref_access(r, has_resp, e); // Transfer happens on the coming edge
        if (has_resp) exp_q.push_back(e);
        issued++;
        @(posedge clk_in);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        req_valid = 1'b0;
        repeat (n) begin
            @(posedge clk_in);
            #1;
        end
    endtask

    // Responses are registered, so they are read on the falling edge
    always @(negedge clk_in) begin
        if (!rst_in && resp_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("A response arrived when none was expected");
                $display("Checks failed");
                $fatal(1);
            end else begin
                exp_head = exp_q.pop_front();
                check_val("resp.fault", {31'h0, resp.fault}, {31'h0, exp_head.fault});
                check_val("resp.addr", resp.addr, exp_head.addr);
                check_val("resp.data", resp.data, exp_head.data);
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk_in);
            cycles++;
            if (cycles > 20 * issued + 200) begin
                $display("Timeout, responses stopped arriving after %0d cycles", cycles);
                $display("Checks failed");
                $fatal(1);
            end
        end
    end

    initial begin
        logic             st;
        lsu_pkg::funct3_t sz;
        lsu_pkg::addr_t   tgt;
        lsu_pkg::addr_t   off;
        int               gap;
        int               drain;
        rst_in = 1'b1;
        req_valid = 1'b0;
        req = '0;
        for (int i = 0; i < `LSU_MEM_WORDS * 4; i++) model[i] = 8'h00;
        repeat (3) @(posedge clk_in);
        #1;
        rst_in = 1'b0;

        repeat (5) begin
            @(negedge clk_in);
            check_val("req_ready", {31'h0, req_ready}, 32'h1);
            check_val("resp_valid", {31'h0, resp_valid}, 32'h0);
        end
        @(posedge clk_in);
        #1;

        // Word stores with a negative offset, then read back
        for (int i = 0; i < 32; i++) begin
            send_req(make_req(1'b1, `LSU_SIZE_W, i*4 + 12, -12, fill_word(i)));
        end
        for (int i = 0; i < 32; i++) send_req(make_req(1'b0, `LSU_SIZE_W, i*4, 0, 0));

        for (int ln = 0; ln < 4; ln++) begin
            send_req(make_req(1'b1, `LSU_SIZE_B, 'h40, ln, 32'hFFFF_FF70 + ln * 'h11));
        end
        send_req(make_req(1'b1, `LSU_SIZE_H, 'h44, 0, 32'h1234_8A5C));
        send_req(make_req(1'b1, `LSU_SIZE_H, 'h44, 2, 32'h0000_31F7));
        for (int a = 'h40; a <= 'h48; a += 4) begin
            for (int ln = 0; ln < 4; ln++) begin
                send_req(make_req(1'b0, `LSU_SIZE_B, a, ln, 0));
                send_req(make_req(1'b0, `LSU_SIZE_BU, a, ln, 0));
            end
            for (int ln = 0; ln < 4; ln += 2) begin
                send_req(make_req(1'b0, `LSU_SIZE_H, a, ln, 0));
                send_req(make_req(1'b0, `LSU_SIZE_HU, a, ln, 0));
            end
            send_req(make_req(1'b0, `LSU_SIZE_W, a, 0, 0));
        end

        // Misaligned halves and words fault
        send_req(make_req(1'b0, `LSU_SIZE_H, 'h49, 0, 0));
        send_req(make_req(1'b0, `LSU_SIZE_HU, 'h4B, 0, 0));
        send_req(make_req(1'b1, `LSU_SIZE_H, 'h4D, 0, 32'hFFFF_FFFF));
        send_req(make_req(1'b0, `LSU_SIZE_W, 'h4A, 0, 0));
        send_req(make_req(1'b1, `LSU_SIZE_W, 'h4F, 0, 32'hFFFF_FFFF));
        send_req(make_req(1'b0, `LSU_SIZE_W, 'h4C, 0, 0));
        send_req(make_req(1'b0, `LSU_SIZE_W, 'h48, 0, 0));

        // Repeated loads hit the tag and stores must clear it
        repeat (3) send_req(make_req(1'b0, `LSU_SIZE_W, 'h50, 0, 0));
        send_req(make_req(1'b1, `LSU_SIZE_W, 'h50, 0, 32'hDEAD_BEEF));
        send_req(make_req(1'b0, `LSU_SIZE_W, 'h50, 0, 0));
        send_req(make_req(1'b0, `LSU_SIZE_H, 'h52, 0, 0));
        send_req(make_req(1'b1, `LSU_SIZE_B, 'h51, 0, 32'h0000_0000));
        repeat (2) send_req(make_req(1'b0, `LSU_SIZE_W, 'h50, 0, 0));

        for (int n = 0; n < 400; n++) begin
            st = $random(seed) & 1;
            sz = st ? sizes[$unsigned($random(seed)) % 3] : sizes[$unsigned($random(seed)) % 5];
            tgt = $random(seed) & 32'h3F;
            off = ($random(seed) & 32'hF) - 32'd8;
            send_req(make_req(st, sz, tgt - off, off, $random(seed)));
            gap = $unsigned($random(seed)) % 8;
            if (gap > 4) idle_cycles(gap - 4); // Mostly back to back so the queue fills
        end

        // At most the issue register and a full queue are still in flight
        drain = 0;
        while (exp_q.size() != 0 && drain < 20 * (`LSU_DEPTH + 2)) begin
            @(posedge clk_in);
            drain++;
        end
        repeat (10) @(posedge clk_in);
        if (exp_q.size() != 0) begin
            $display("Responses are still outstanding at the end of the run");
            $display("Checks failed");
            $fatal(1);
        end else begin
            $display("All checks passed");
            $finish;
        end
    end
endmodule

// ==== flist.f ====
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_issue.sv
logic/lsu_req_fifo.sv
logic/dcache_port.sv
logic/dmem_bram.sv
logic/lsu_top.sv
sim/tb_clkgen.sv
sim/tb_lsu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_lsu -f flist.f \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_lsu > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log
grep -q "Checks failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All checks passed" sim.log && echo "Simulation PASSED" \
    || { echo "Simulation gave no result"; exit 1; }
